//--- flist.f
+incdir+common
common/softmax_pkg.sv
softmax/exp_lut.sv
softmax/exp_fifo.sv
softmax/row_exp_sum.sv
softmax/norm_div.sv
softmax/softmax_top.sv
bench/tb_softmax.sv

//--- Makefile
# Verilator build and run for the softmax engine

TOP = tb_softmax
SIM = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f --Mdir obj_dir -o V$(TOP)

run: compile
	-./$(SIM) > run.log 2>&1
	@cat run.log
	@grep -q "TB PASSED" run.log || (echo "simulation failed, see run.log"; exit 1)

clean:
	rm -rf obj_dir run.log

//--- bench/tb_softmax.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module tb_softmax;

  localparam int NUM        = `SM_ROWS * `SM_LANES;
  localparam int DEPTH      = softmax_pkg::SM_DEPTH;
  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop
  localparam softmax_pkg::in_t IN_MAX = {1'b0, {(`SM_IN_W-1){1'b1}}};
  localparam softmax_pkg::in_t IN_MIN = {1'b1, {(`SM_IN_W-1){1'b0}}};

  logic              clk;
  logic              arst_n;
  softmax_pkg::in_t  in_data [NUM-1:0];
  logic              in_valid;
  logic              in_ready;
  softmax_pkg::out_t out_data [NUM-1:0];
  logic              out_valid;
  logic              out_ready;

  int                seed;
  int                ready_seed;
  int                ready_mode;  // 0 always ready, 1 random, 2 stalled
  int                gap_max;     // idle cycles allowed between input beats
  softmax_pkg::in_t  vec [DEPTH-1:0][NUM-1:0];

  softmax_pkg::out_t exp_q [$];   // expected output elements in order
  softmax_pkg::exp_t beat_exp [DEPTH-1:0][NUM-1:0];
  int                row_tot [`SM_ROWS-1:0];
  int                beat_in_vec;
  logic              held;
  softmax_pkg::out_t held_data [NUM-1:0];

  softmax_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // e^(s/16) * 256, rounded and held within 1..4095
  function automatic softmax_pkg::exp_t exp_code(input softmax_pkg::in_t s);
    real x;
    int  c;
    x = $exp($itor(s) / real'(1 << `SM_IN_FRAC)) * real'(1 << `SM_EXP_FRAC);
    c = (x > real'((1 << `SM_EXP_W) - 1)) ? (1 << `SM_EXP_W) - 1 : $rtoi(x + 0.5);
    c = (c < 1) ? 1 : c;
    return softmax_pkg::exp_t'(c);
  endfunction

  function automatic softmax_pkg::out_t norm_out(input softmax_pkg::exp_t e, input int total);
    int q;
    q = (int'(e) << `SM_OUT_FRAC) / total;
    return softmax_pkg::out_t'(q);  // low output bits only
  endfunction

  task automatic check_exp(input softmax_pkg::exp_t got, input softmax_pkg::exp_t want,
                           input int idx);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0d ns: exponent of element %0d is %0d, expected %0d",
                          $time, idx, got, want));
    end
  endtask

  task automatic check_out(input softmax_pkg::out_t got, input softmax_pkg::out_t want,
                           input int idx);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0d ns: output element %0d is %0d, expected %0d",
                          $time, idx, got, want));
    end
  endtask

  task automatic record_beat();
    softmax_pkg::exp_t e;
    for (int i = 0; i < NUM; i++) begin
      e = exp_code(in_data[i]);
      check_exp(dut_i.exp_data[i], e, i);
      beat_exp[beat_in_vec][i] = e;
      row_tot[i / `SM_LANES] += int'(e);
    end
    beat_in_vec++;
    if (beat_in_vec == DEPTH) begin  // vector complete, outputs now known
      for (int b = 0; b < DEPTH; b++) begin
        for (int i = 0; i < NUM; i++) begin
          exp_q.push_back(norm_out(beat_exp[b][i], row_tot[i / `SM_LANES]));
        end
      end
      for (int r = 0; r < `SM_ROWS; r++) begin
        row_tot[r] = 0;
      end
      beat_in_vec = 0;
    end
  endtask

  // sampled mid-cycle, so each sample describes the next rising edge
  always @(negedge clk) begin
    if (arst_n !== 1'b1) begin
      held = 1'b0;
      if (out_valid !== 1'b0) begin
        abort_run("out_valid was not low during reset");
      end
    end else begin
      if (held) begin
        if (out_valid !== 1'b1) begin
          abort_run($sformatf("Fail at %0d ns: out_valid dropped before transfer", $time));
        end
        for (int i = 0; i < NUM; i++) begin
          if (out_data[i] !== held_data[i]) begin
            abort_run($sformatf("Fail at %0d ns: out_data %0d changed while stalled",
                                $time, i));
          end
        end
      end
      if (out_valid === 1'b1 && exp_q.size() < NUM) begin
        abort_run("an output beat appeared before its input vector was complete");
      end
      if (out_valid && out_ready) begin
        for (int i = 0; i < NUM; i++) begin
          check_out(out_data[i], exp_q.pop_front(), i);
        end
      end
      held      = out_valid && !out_ready;
      held_data = out_data;
      if (in_valid && in_ready) begin
        record_beat();
      end
    end
  end

  initial begin
    ready_seed = 32'h34f9 ^ 32'h0000_ffff;  // separate stream for out_ready
    out_ready  = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        0:       out_ready = 1'b1;
        1:       out_ready = ($unsigned($random(ready_seed)) % 4) != 0;
        default: out_ready = 1'b0;
      endcase
    end
  end

  // mode changes land mid-cycle so the ready driver never races them
  task automatic set_phase(input int rmode, input int gmax);
    @(negedge clk);
    ready_mode = rmode;
    gap_max    = gmax;
    @(posedge clk);
    #2;
  endtask

  task automatic gen_vector(input int kind);
    for (int b = 0; b < DEPTH; b++) begin
      for (int i = 0; i < NUM; i++) begin
        case (kind)
          1:       vec[b][i] = IN_MAX;
          2:       vec[b][i] = IN_MIN;
          3:       vec[b][i] = ((b * NUM + i) % 3 == 0) ? IN_MAX :
                               ((b * NUM + i) % 3 == 1) ? IN_MIN :
                               softmax_pkg::in_t'($random(seed));
          default: vec[b][i] = softmax_pkg::in_t'($random(seed));
        endcase
      end
    end
  endtask

  task automatic send_beat(input int b);
    int   waited;
    logic taken;
    int   idle;
    in_data  = vec[b];
    in_valid = 1'b1;
    waited   = 0;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #2;
      waited++;
      if (!taken && waited > WAIT_LIMIT) begin
        abort_run($sformatf("input beat was not accepted within %0d cycles", WAIT_LIMIT));
      end
    end
    in_valid = 1'b0;
    idle = (gap_max > 0) ? $unsigned($random(seed)) % (gap_max + 1) : 0;
    repeat (idle) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_vector();
    for (int b = 0; b < DEPTH; b++) begin
      send_beat(b);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("expected output beats did not arrive before the timeout");
      end
    end
    repeat (5) @(posedge clk);
    #2;
  endtask

  task automatic stall_test();
    int waited;
    set_phase(2, 0);
    gen_vector(0);
    send_vector();
    gen_vector(0);
    in_data  = vec[0];
    in_valid = 1'b1;
    waited   = 0;
    @(negedge clk);
    while (in_ready !== 1'b0) begin  // FIFO and summers back up
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("in_ready never went low while out_ready was held low");
      end
      @(negedge clk);
    end
    repeat (60) begin
      @(negedge clk);
      if (in_ready !== 1'b0) begin
        abort_run("in_ready rose while out_ready was still held low");
      end
    end
    set_phase(0, 0);
    send_vector();
  endtask

  initial begin
    seed       = 32'h34f9;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    ready_mode = 0;
    gap_max    = 0;
    for (int i = 0; i < NUM; i++) begin
      in_data[i] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    set_phase(0, 0);  // streaming, no back-pressure
    repeat (6) begin
      gen_vector(0);
      send_vector();
    end
    drain();

    set_phase(1, 3);  // gaps on both sides
    repeat (10) begin
      gen_vector(0);
      send_vector();
    end
    drain();

    set_phase(0, 0);  // both clamps
    for (int k = 1; k <= 3; k++) begin
      gen_vector(k);
      send_vector();
    end
    drain();

    stall_test();
    drain();

    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run("some expected output beats were never produced");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- softmax/softmax_top.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module softmax_top (
  input  logic              clk,
  input  logic              arst_n,
  input  softmax_pkg::in_t  in_data [`SM_ROWS*`SM_LANES-1:0],
  input  logic              in_valid,
  output logic              in_ready,
  output softmax_pkg::out_t out_data [`SM_ROWS*`SM_LANES-1:0],
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int NUM = `SM_ROWS * `SM_LANES;

  softmax_pkg::exp_t exp_data [NUM-1:0];     // lookup outputs
  softmax_pkg::exp_t ff_exp_data [NUM-1:0];  // buffered exponents
  logic              fifo_wr_valid;
  logic              fifo_wr_ready;
  logic              fifo_rd_valid;
  logic              fifo_rd_ready;
  logic              sum_in_valid;
  logic              sum_in_ready [`SM_ROWS-1:0];
  softmax_pkg::acc_t row_total [`SM_ROWS-1:0];
  logic              total_valid [`SM_ROWS-1:0];
  logic              total_ready;

  // a beat goes to both the fifo and the summers or to neither
  assign in_ready      = fifo_wr_ready && sum_in_ready[0];
  assign fifo_wr_valid = in_valid && sum_in_ready[0];
  assign sum_in_valid  = in_valid && fifo_wr_ready;

  for (genvar i = 0; i < NUM; i++) begin : g_lut
    exp_lut exp_map (
      .sample (in_data[i]),
      .expo   (exp_data[i])
    );
  end

  exp_fifo exp_buffer (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_data  (exp_data),
    .wr_valid (fifo_wr_valid),
    .wr_ready (fifo_wr_ready),
    .rd_data  (ff_exp_data),
    .rd_valid (fifo_rd_valid),
    .rd_ready (fifo_rd_ready)
  );

  for (genvar r = 0; r < `SM_ROWS; r++) begin : g_row
    row_exp_sum row_sum (
      .clk         (clk),
      .arst_n      (arst_n),
      .lanes_in    (exp_data[r*`SM_LANES +: `SM_LANES]),
      .in_valid    (sum_in_valid),
      .in_ready    (sum_in_ready[r]),
      .total       (row_total[r]),
      .total_valid (total_valid[r]),
      .total_ready (total_ready)
    );
  end

  norm_div divider (
    .clk            (clk),
    .arst_n         (arst_n),
    .dividend       (ff_exp_data),
    .dividend_valid (fifo_rd_valid),
    .dividend_ready (fifo_rd_ready),
    .divisor        (row_total),
    .divisor_valid  (total_valid[0]),  // row 0 speaks for all rows
    .divisor_ready  (total_ready),
    .quotient       (out_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

endmodule

//--- softmax/norm_div.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module norm_div (
  input  logic              clk,
  input  logic              arst_n,
  input  softmax_pkg::exp_t dividend [`SM_ROWS*`SM_LANES-1:0],
  input  logic              dividend_valid,
  output logic              dividend_ready,
  input  softmax_pkg::acc_t divisor [`SM_ROWS-1:0],
  input  logic              divisor_valid,
  output logic              divisor_ready,
  output softmax_pkg::out_t quotient [`SM_ROWS*`SM_LANES-1:0],
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int NUM    = `SM_ROWS * `SM_LANES;
  localparam int DIVD_W = softmax_pkg::DIVD_W;
  localparam int QUO_W  = softmax_pkg::QUO_W;
  localparam int ACC_W  = softmax_pkg::ACC_W;
  localparam int PRE_W  = DIVD_W - QUO_W;   // top dividend bits preloaded as remainder
  localparam int STEP_W = $clog2(QUO_W);

  logic              busy;
  logic [STEP_W-1:0] step;
  logic              load;
  logic              last_step;
  logic              pop;

  assign load      = !busy && !out_valid && dividend_valid && divisor_valid;
  assign last_step = busy && (step == STEP_W'(QUO_W - 1));
  assign pop       = out_valid && out_ready;

  // fifo head and total stay put until the result is taken
  assign dividend_ready = pop;
  assign divisor_ready  = pop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      step      <= '0;
      out_valid <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
      step <= '0;
    end else if (busy) begin
      if (last_step) begin
        busy      <= 1'b0;
        step      <= '0;
        out_valid <= 1'b1;
      end else begin
        step <= step + 1'b1;
      end
    end else if (pop) begin
      out_valid <= 1'b0;
    end
  end

  for (genvar i = 0; i < NUM; i++) begin : g_elem
    localparam int ROW = i / `SM_LANES;

    logic [DIVD_W-1:0] ext;    // exponent scaled by 2^SM_OUT_FRAC
    logic [ACC_W-1:0]  rem_q;
    logic [QUO_W-1:0]  sh_q;   // dividend bits out at the top, quotient bits in at the bottom
    logic [ACC_W:0]    trial;
    logic [ACC_W:0]    diff;
    logic              fits;

    assign ext   = DIVD_W'(dividend[i]) << `SM_OUT_FRAC;
    assign trial = {rem_q, sh_q[QUO_W-1]};
    assign diff  = trial - {1'b0, divisor[ROW]};
    assign fits  = !diff[ACC_W];  // no borrow means subtract

    always_ff @(posedge clk) begin
      if (load) begin
        rem_q <= ACC_W'(ext[DIVD_W-1 -: PRE_W]);
        sh_q  <= ext[QUO_W-1:0];
      end else if (busy) begin
        rem_q <= fits ? diff[ACC_W-1:0] : trial[ACC_W-1:0];
        sh_q  <= {sh_q[QUO_W-2:0], fits};
      end
    end

    assign quotient[i] = sh_q[`SM_OUT_W-1:0];  // truncate to output width
  end

  for (genvar r = 0; r < `SM_ROWS; r++) begin : g_chk
    a_divisor_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
      load |-> divisor[r] != '0);
  end

endmodule

//--- softmax/row_exp_sum.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module row_exp_sum (
  input  logic              clk,
  input  logic              arst_n,
  input  softmax_pkg::exp_t lanes_in [`SM_LANES-1:0],
  input  logic              in_valid,
  output logic              in_ready,
  output softmax_pkg::acc_t total,
  output logic              total_valid,
  input  logic              total_ready
);

  localparam int DEPTH = softmax_pkg::SM_DEPTH;
  localparam int CNT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  softmax_pkg::sum_t lane_sum;
  softmax_pkg::sum_t sum_q;     // registered beat sum
  logic              sum_valid;
  logic              in_fire;
  logic              acc_take;
  logic              replay_fire;
  softmax_pkg::acc_t acc_q;
  logic [CNT_W-1:0]  beat_cnt;
  logic [CNT_W-1:0]  replay_cnt;
  logic              hold;      // finished total on offer

  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < `SM_LANES; l++) begin
      lane_sum = lane_sum + softmax_pkg::sum_t'(lanes_in[l]);
    end
  end

  assign in_ready    = !hold;  // stall input while the total replays
  assign in_fire     = in_valid && in_ready;
  assign acc_take    = sum_valid && !hold;
  assign replay_fire = hold && total_ready;
  assign total       = acc_q;
  assign total_valid = hold;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_valid <= 1'b0;
    end else if (in_fire) begin
      sum_valid <= 1'b1;
    end else if (acc_take) begin
      sum_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      sum_q <= lane_sum;
    end
  end

  // accumulate SM_DEPTH beats, then offer the total once per vector beat
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_q      <= '0;
      beat_cnt   <= '0;
      replay_cnt <= '0;
      hold       <= 1'b0;
    end else if (replay_fire) begin
      if (replay_cnt == CNT_W'(DEPTH - 1)) begin
        replay_cnt <= '0;
        hold       <= 1'b0;
        acc_q      <= '0;  // ready for next vector
      end else begin
        replay_cnt <= replay_cnt + 1'b1;
      end
    end else if (acc_take) begin
      acc_q <= acc_q + softmax_pkg::acc_t'(sum_q);
      if (beat_cnt == CNT_W'(DEPTH - 1)) begin
        beat_cnt <= '0;
        hold     <= 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  a_beat_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    beat_cnt < CNT_W'(DEPTH));
  // lookup clamp guarantees every lane contributes at least one
  a_total_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    total_valid |-> total != '0);

endmodule

//--- softmax/exp_fifo.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module exp_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  softmax_pkg::exp_t wr_data [`SM_ROWS*`SM_LANES-1:0],
  input  logic              wr_valid,
  output logic              wr_ready,
  output softmax_pkg::exp_t rd_data [`SM_ROWS*`SM_LANES-1:0],
  output logic              rd_valid,
  input  logic              rd_ready
);

  localparam int NUM   = `SM_ROWS * `SM_LANES;
  localparam int DEPTH = softmax_pkg::SM_DEPTH;  // one whole vector
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  softmax_pkg::exp_t mem [DEPTH-1:0][NUM-1:0];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              wr_fire;
  logic              rd_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready = (count != CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;
  assign rd_data  = mem[rd_ptr];  // head beat, combinational read

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers meeting means empty or full, never a live slot overwritten or a dead one read
  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
    wr_fire |-> !(wr_ptr == rd_ptr && count != '0));
  a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
    rd_fire |-> !(wr_ptr == rd_ptr && count != CNT_W'(DEPTH)));

endmodule

//--- softmax/exp_lut.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module exp_lut (
  input  softmax_pkg::in_t  sample,
  output softmax_pkg::exp_t expo
);

  localparam int ENTRIES = 2 ** `SM_IN_W;
  localparam int EXP_MAX = 2 ** `SM_EXP_W - 1;

  typedef softmax_pkg::exp_t table_t [ENTRIES];

  // e^(sample/16) * 256, rounded and clamped to 1..EXP_MAX
  function automatic table_t build_table();
    table_t tbl;
    int     val;
    int     code;
    real    scaled;
    for (int i = 0; i < ENTRIES; i++) begin
      val = (i >= ENTRIES / 2) ? i - ENTRIES : i;  // index read as two's complement
      scaled = $exp(real'(val) / real'(2 ** `SM_IN_FRAC)) * real'(2 ** `SM_EXP_FRAC);
      if (scaled >= real'(EXP_MAX)) begin
        code = EXP_MAX;  // upper clamp
      end else begin
        code = $rtoi(scaled + 0.5);
      end
      if (code < 1) begin
        code = 1;  // keeps every row total nonzero
      end
      tbl[i] = softmax_pkg::exp_t'(code);
    end
    return tbl;
  endfunction

  localparam table_t EXP_TABLE = build_table();

  assign expo = EXP_TABLE[$unsigned(sample)];  // raw sample bits as address

endmodule

//--- common/softmax_pkg.sv
`include "softmax_cfg.svh"

package softmax_pkg;

  // beats per vector
  localparam int SM_DEPTH = `SM_VEC_LEN / `SM_LANES;

  // growth of the per-beat row sum and of the vector total
  localparam int SUM_W = `SM_EXP_W + $clog2(`SM_LANES);
  localparam int ACC_W = SUM_W + $clog2(SM_DEPTH);

  // divider operand and quotient widths
  localparam int DIVD_W = `SM_EXP_W + `SM_OUT_FRAC;
  localparam int QUO_W  = `SM_OUT_W + `SM_OUT_FRAC;

  typedef logic signed [`SM_IN_W-1:0] in_t;

  typedef logic [`SM_EXP_W-1:0] exp_t;

  typedef logic [SUM_W-1:0] sum_t;

  typedef logic [ACC_W-1:0] acc_t;

  typedef logic [`SM_OUT_W-1:0] out_t;

endpackage

//--- common/softmax_cfg.svh
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// signed q4.4 input samples
`define SM_IN_W      8
`define SM_IN_FRAC   4

// unsigned exponent words
`define SM_EXP_W     12
`define SM_EXP_FRAC  8

// unsigned outputs where 1.0 is 16
`define SM_OUT_FRAC  4
`define SM_OUT_W     6

`define SM_LANES     3   // samples per row per beat
`define SM_ROWS      2   // rows per beat
`define SM_VEC_LEN   9   // multiple of SM_LANES

`endif
